// File: mem_stage.f
common/lsu_pkg.sv
common/axi_pkg.sv
lsu/lsu_data_align.sv
lsu/lsu.sv
logic/axi_sram.sv
logic/mem_stage.sv
testbench/tb_mem_stage.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
TOP        := tb_mem_stage
FILELIST   := mem_stage.f
BUILD_DIR  := obj_dir
LOG        := sim.log

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_mem_stage.sv
/* tb_mem_stage: testbench for the memory stage, checks every result
   against a shadow copy of the data SRAM */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage
    import lsu_pkg::*, axi_pkg::*;
();

    localparam int clk_period = 20;
    localparam int total_instr = sram_words + 32 + 96 + 96 + 16 + 64;

    logic        clock = 1'b0;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    exe_to_mem_t in_data;
    logic        out_valid;
    logic        out_ready = 1'b1;
    mem_to_wb_t  out_data;

    logic [31:0] shadow [sram_words];
    mem_to_wb_t  exp_q [$];
    mem_to_wb_t  exp_item;
    mem_to_wb_t  got_item;
    mem_to_wb_t  held_data;
    logic        held = 1'b0;
    logic        seen_accept = 1'b0;
    logic        stall_mode = 1'b0;
    logic [2:0]  stretch = 3'd0;
    logic [31:0] lcg_state = 32'd85660;
    logic [31:0] stall_state = 32'd85660;
    logic [31:0] base;
    int          issued = 0;
    int          done_count = 0;

    mem_stage dut (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #(clk_period / 2) clock = ~clock;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_step(lcg_state);
        return {lcg_state[15:0], lcg_state[31:16]};   // low lcg bits are weak
    endfunction

    function automatic exe_to_mem_t random_payload();
        exe_to_mem_t item;
        logic [31:0] r;
        item.pc = next_rand();
        item.result = next_rand();
        item.store_data = next_rand();
        item.csr_value = next_rand();
        r = next_rand();
        item.rd = r[4:0];
        item.reg_write = r[5];
        item.csr_write = r[9:6];
        item.jump = r[10];
        item.mem_read = 1'b0;
        item.mem_write = 1'b0;
        item.funct3 = mem_word;
        return item;
    endfunction

    function automatic mem_to_wb_t to_wb(input exe_to_mem_t item, input logic [31:0] load_value);
        mem_to_wb_t wb;
        wb.pc = item.pc;
        wb.result = item.result;
        wb.load_data = load_value;
        wb.rd = item.rd;
        wb.reg_write = item.reg_write;
        wb.csr_write = item.csr_write;
        wb.csr_value = item.csr_value;
        wb.jump = item.jump;
        wb.mem_read = item.mem_read;
        return wb;
    endfunction

    function automatic void update_shadow(input mem_op_e op, input logic [31:0] addr,
                                          input logic [31:0] data);
        logic [3:0][7:0] lanes;
        lanes = shadow[addr[sram_idx_w+1:2]];
        case (op)
            mem_byte, mem_byte_u: lanes[addr[1:0]] = data[7:0];
            mem_half, mem_half_u: begin
                lanes[{addr[1], 1'b0}] = data[7:0];
                lanes[{addr[1], 1'b1}] = data[15:8];
            end
            default: lanes = data;
        endcase
        shadow[addr[sram_idx_w+1:2]] = lanes;
    endfunction

    function automatic logic [31:0] expected_load(input mem_op_e op, input logic [31:0] addr);
        logic [3:0][7:0] lanes;
        logic [7:0]      sel_b;
        logic [15:0]     sel_h;
        logic [31:0]     value;
        lanes = shadow[addr[sram_idx_w+1:2]];
        sel_b = lanes[addr[1:0]];
        sel_h = {lanes[{addr[1], 1'b1}], lanes[{addr[1], 1'b0}]};
        case (op)
            mem_byte:   value = {{24{sel_b[7]}}, sel_b};
            mem_byte_u: value = {24'd0, sel_b};
            mem_half:   value = {{16{sel_h[15]}}, sel_h};
            mem_half_u: value = {16'd0, sel_h};
            default:    value = lanes;
        endcase
        return value;
    endfunction

    task automatic issue(input exe_to_mem_t item);
        @(negedge clock);
        while (!in_ready) @(negedge clock);
        in_valid = 1'b1;
        in_data = item;
        issued++;
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic store_access(input logic [31:0] addr, input logic [31:0] data,
                                input mem_op_e op);
        exe_to_mem_t item;
        item = random_payload();
        item.result = addr;
        item.store_data = data;
        item.mem_write = 1'b1;
        item.funct3 = op;
        update_shadow(op, addr, data);
        exp_q.push_back(to_wb(item, 32'd0));
        issue(item);
    endtask

    task automatic load_access(input logic [31:0] addr, input mem_op_e op);
        exe_to_mem_t item;
        item = random_payload();
        item.result = addr;
        item.mem_read = 1'b1;
        item.funct3 = op;
        exp_q.push_back(to_wb(item, expected_load(op, addr)));
        issue(item);
    endtask

    task automatic plain_instr();
        exe_to_mem_t item;
        item = random_payload();
        exp_q.push_back(to_wb(item, 32'd0));
        issue(item);
    endtask

    reset_idle: assert property (@(posedge clock) disable iff (reset)
        !seen_accept |-> in_ready && !out_valid)
        else stop_on_error("stage not idle after reset");
    busy_blocks_input: assert property (@(posedge clock) disable iff (reset)
        out_valid |-> !in_ready)
        else stop_on_error("in_ready high while a result is waiting");
    hold_valid: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid)
        else stop_on_error("out_valid dropped under back-pressure");
    pass_latency: assert property (@(posedge clock) disable iff (reset)
        in_valid && in_ready && !in_data.mem_read && !in_data.mem_write |=> out_valid)
        else stop_on_error("pass-through result not valid one cycle after acceptance");

    always @(posedge clock) begin
        if (!reset) begin
            if (in_valid && in_ready) seen_accept <= 1'b1;
            if (held) begin
                assert (out_data == held_data)
                    else stop_on_error($sformatf("mismatch out_data: got %h expected %h",
                                                 out_data, held_data));
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    stop_on_error("result produced with no instruction outstanding");
                end else begin
                    exp_item = exp_q.pop_front();
                    got_item = out_data;
                    if (!exp_item.mem_read) got_item.load_data = '0;  // only loads return data
                    assert (got_item.load_data == exp_item.load_data)
                        else stop_on_error($sformatf("mismatch load_data: got %h expected %h",
                                                     got_item.load_data, exp_item.load_data));
                    assert (got_item == exp_item)
                        else stop_on_error($sformatf("mismatch out_data: got %h expected %h",
                                                     got_item, exp_item));
                    done_count++;
                end
            end
            held <= out_valid && !out_ready;
            held_data <= out_data;
        end
    end

    // out_ready toggles with random stretch lengths
    always @(negedge clock) begin
        if (!stall_mode) begin
            out_ready = 1'b1;
        end else if (stretch != 3'd0) begin
            stretch = stretch - 3'd1;
        end else begin
            stall_state = lcg_step(stall_state);
            out_ready = ~out_ready;
            stretch = stall_state[20:18];
        end
    end

    initial begin
        repeat ((total_instr + 8) * 200) @(posedge clock);
        stop_on_error("watchdog expired before all instructions completed");
    end

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < sram_words; i++) begin
            store_access(32'(i) << 2, next_rand(), mem_word);   // defined contents
        end
        for (int i = 0; i < 16; i++) begin
            base = next_rand() & 32'hffff_fffc;
            store_access(base, next_rand(), mem_word);
            load_access(base, mem_word);
        end
        for (int i = 0; i < 8; i++) begin
            base = next_rand() & 32'hffff_fffc;
            for (int lane = 0; lane < 4; lane++) begin
                store_access(base | lane, next_rand(), mem_byte);
                load_access(base, mem_word);
            end
            for (int lane = 0; lane < 4; lane += 2) begin
                store_access(base | lane, next_rand(), mem_half);
                load_access(base, mem_word);
            end
        end
        for (int i = 0; i < 8; i++) begin
            base = next_rand() & 32'hffff_fffc;
            for (int lane = 0; lane < 4; lane++) begin
                load_access(base | lane, mem_byte);
                load_access(base | lane, mem_byte_u);
            end
            for (int lane = 0; lane < 4; lane += 2) begin
                load_access(base | lane, mem_half);
                load_access(base | lane, mem_half_u);
            end
        end
        repeat (16) plain_instr();
        stall_mode = 1'b1;
        for (int i = 0; i < 16; i++) begin
            base = next_rand() & 32'hffff_fffc;
            store_access(base, next_rand(), mem_word);
            load_access(base | (i % 4), mem_byte);
            plain_instr();
            load_access(base, mem_word);
        end
        wait (done_count == issued);
        stall_mode = 1'b0;
        repeat (10) @(negedge clock);
        if (exp_q.size() != 0 || done_count != total_instr) begin
            stop_on_error("instruction count at the output does not match the input");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: logic/mem_stage.sv
/* mem_stage: memory subsystem top, the load/store unit driving
   a local AXI4 data SRAM */
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import lsu_pkg::*, axi_pkg::*;
(
    input  wire              clock,
    input  wire              reset,
    input  wire              in_valid,
    output logic             in_ready,
    input  wire exe_to_mem_t in_data,
    output logic             out_valid,
    input  wire              out_ready,
    output mem_to_wb_t       out_data
);

    logic    awvalid, awready;
    logic    wvalid, wready;
    logic    bvalid, bready;
    logic    arvalid, arready;
    logic    rvalid, rready;
    axi_aw_t aw;
    axi_w_t  w;
    axi_b_t  b;
    axi_ar_t ar;
    axi_r_t  r;

    lsu u_lsu (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .awvalid   (awvalid),
        .awready   (awready),
        .aw        (aw),
        .wvalid    (wvalid),
        .wready    (wready),
        .w         (w),
        .bvalid    (bvalid),
        .bready    (bready),
        .b         (b),
        .arvalid   (arvalid),
        .arready   (arready),
        .ar        (ar),
        .rvalid    (rvalid),
        .rready    (rready),
        .r         (r)
    );

    axi_sram u_sram (
        .clock   (clock),
        .reset   (reset),
        .awvalid (awvalid),
        .awready (awready),
        .aw      (aw),
        .wvalid  (wvalid),
        .wready  (wready),
        .w       (w),
        .bvalid  (bvalid),
        .bready  (bready),
        .b       (b),
        .arvalid (arvalid),
        .arready (arready),
        .ar      (ar),
        .rvalid  (rvalid),
        .rready  (rready),
        .r       (r)
    );

endmodule

`default_nettype wire

// File: logic/axi_sram.sv
/* axi_sram: single-beat AXI4 slave in front of a word-wide memory
   with byte strobes, one response outstanding per direction */
`timescale 1ns/1ps
`default_nettype none

module axi_sram
    import axi_pkg::*;
(
    input  wire           clock,
    input  wire           reset,

    input  wire           awvalid,
    output logic          awready,
    input  wire axi_aw_t  aw,
    input  wire           wvalid,
    output logic          wready,
    input  wire axi_w_t   w,
    output logic          bvalid,
    input  wire           bready,
    output axi_b_t        b,
    input  wire           arvalid,
    output logic          arready,
    input  wire axi_ar_t  ar,
    output logic          rvalid,
    input  wire           rready,
    output axi_r_t        r
);

    logic [axi_data_w-1:0] mem [sram_words];

    logic                  aw_held;
    logic                  w_held;
    axi_aw_t               aw_q;
    axi_w_t                w_q;
    axi_aw_t               aw_eff;
    axi_w_t                w_eff;
    logic                  have_aw;
    logic                  have_w;
    logic                  wr_fire;
    logic [sram_idx_w-1:0] wr_idx;
    logic [sram_idx_w-1:0] rd_idx;
    logic [axi_id_w-1:0]   b_id_q;
    logic [axi_id_w-1:0]   r_id_q;
    logic [axi_data_w-1:0] r_data_q;

    // no new address or data while the write response waits
    assign awready = !aw_held && !bvalid;
    assign wready = !w_held && !bvalid;
    assign arready = !rvalid;

    // aw and w may arrive in either order, or together
    assign have_aw = aw_held || (awvalid && awready);
    assign have_w = w_held || (wvalid && wready);
    assign aw_eff = aw_held ? aw_q : aw;
    assign w_eff = w_held ? w_q : w;
    assign wr_fire = have_aw && have_w;

    assign wr_idx = aw_eff.addr[sram_idx_w+1:2];   // wraps at the depth
    assign rd_idx = ar.addr[sram_idx_w+1:2];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            aw_held <= 1'b0;
            w_held <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            aw_held <= have_aw && !wr_fire;
            w_held <= have_w && !wr_fire;
            if (wr_fire) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            if (arvalid && arready) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (awvalid && awready) aw_q <= aw;
        if (wvalid && wready) w_q <= w;
        if (wr_fire) begin
            b_id_q <= aw_eff.id;
            for (int i = 0; i < axi_strb_w; i++) begin
                if (w_eff.strb[i]) mem[wr_idx][8*i +: 8] <= w_eff.data[8*i +: 8];
            end
        end
        if (arvalid && arready) begin
            r_data_q <= mem[rd_idx];
            r_id_q <= ar.id;
        end
    end

    assign b = '{resp: resp_okay, id: b_id_q};
    assign r = '{data: r_data_q, resp: resp_okay, id: r_id_q, last: 1'b1};

endmodule

`default_nettype wire

// File: lsu/lsu.sv
/* lsu: memory stage of the pipeline, registers one instruction and
   runs it as an AXI4 read, an AXI4 write or a plain pass-through */
`timescale 1ns/1ps
`default_nettype none

module lsu
    import lsu_pkg::*, axi_pkg::*;
(
    input  wire           clock,
    input  wire           reset,

    input  wire           in_valid,
    output logic          in_ready,
    input  wire exe_to_mem_t in_data,

    output logic          out_valid,
    input  wire           out_ready,
    output mem_to_wb_t    out_data,

    output logic          awvalid,
    input  wire           awready,
    output axi_aw_t       aw,
    output logic          wvalid,
    input  wire           wready,
    output axi_w_t        w,
    input  wire           bvalid,
    output logic          bready,
    input  wire axi_b_t   b,
    output logic          arvalid,
    input  wire           arready,
    output axi_ar_t       ar,
    input  wire           rvalid,
    output logic          rready,
    input  wire axi_r_t   r
);

    typedef enum logic [1:0] {
        st_idle,
        st_read_wait,
        st_write_wait,
        st_done
    } state_e;

    state_e            state;
    exe_to_mem_t       mem_q;          // instruction held by the stage
    logic [xlen-1:0]   load_q;
    logic [xlen-1:0]   wdata;
    logic [xlen/8-1:0] wstrb;
    logic [xlen-1:0]   load_aligned;
    axi_ax_t           req_addr;

    assign in_ready = (state == st_idle);
    assign out_valid = (state == st_done);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            arvalid <= 1'b0;
            rready <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            bready <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (in_valid) begin
                        if (in_data.mem_read) begin
                            state <= st_read_wait;
                            arvalid <= 1'b1;
                            rready <= 1'b1;
                        end else if (in_data.mem_write) begin
                            state <= st_write_wait;
                            awvalid <= 1'b1;
                            wvalid <= 1'b1;
                            bready <= 1'b1;
                        end else begin
                            state <= st_done;       // one register stage only
                        end
                    end
                end
                st_read_wait: begin
                    if (arvalid && arready) arvalid <= 1'b0;
                    if (rvalid && rready) begin
                        rready <= 1'b0;
                        state <= st_done;
                    end
                end
                st_write_wait: begin
                    if (awvalid && awready) awvalid <= 1'b0;
                    if (wvalid && wready) wvalid <= 1'b0;
                    if (bvalid && bready) begin     // resp is always okay
                        bready <= 1'b0;
                        state <= st_done;
                    end
                end
                st_done: begin
                    if (out_ready) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid && in_ready) mem_q <= in_data;
        if (rvalid && rready) load_q <= load_aligned;
    end

    lsu_data_align u_align (
        .funct3     (mem_q.funct3),
        .addr_low   (mem_q.result[1:0]),
        .store_data (mem_q.store_data),
        .bus_rdata  (r.data),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .load_data  (load_aligned)
    );

    // size follows the access width, signedness does not matter here
    assign req_addr = '{
        addr:  mem_q.result,
        id:    axi_id,
        len:   axi_len_single,
        size:  {1'b0, mem_q.funct3[1:0]},
        burst: burst_fixed
    };
    assign aw = req_addr;
    assign ar = req_addr;
    assign w = '{data: wdata, strb: wstrb, last: 1'b1};

    assign out_data = '{
        pc:        mem_q.pc,
        result:    mem_q.result,
        load_data: mem_q.mem_read ? load_q : '0,
        rd:        mem_q.rd,
        reg_write: mem_q.reg_write,
        csr_write: mem_q.csr_write,
        csr_value: mem_q.csr_value,
        jump:      mem_q.jump,
        mem_read:  mem_q.mem_read
    };

endmodule

`default_nettype wire

// File: lsu/lsu_data_align.sv
/* lsu_data_align: moves store data into byte lanes with strobes,
   and picks and extends load bytes from the bus word */
`timescale 1ns/1ps
`default_nettype none

module lsu_data_align
    import lsu_pkg::*;
(
    input  wire mem_op_e       funct3,
    input  wire [1:0]          addr_low,
    input  wire [xlen-1:0]     store_data,
    input  wire [xlen-1:0]     bus_rdata,
    output logic [xlen-1:0]    wdata,
    output logic [xlen/8-1:0]  wstrb,
    output logic [xlen-1:0]    load_data
);

    logic [4:0]  byte_shift;
    logic [4:0]  half_shift;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign byte_shift = {addr_low, 3'b000};
    assign half_shift = {addr_low[1], 4'b0000};    // halfwords sit on even lanes

    assign byte_sel = bus_rdata[byte_shift +: 8];
    assign half_sel = bus_rdata[half_shift +: 16];

    always_comb begin
        case (funct3)
            mem_byte, mem_byte_u: begin
                wdata = {24'b0, store_data[7:0]} << byte_shift;
                wstrb = 4'b0001 << addr_low;
            end
            mem_half, mem_half_u: begin
                wdata = {16'b0, store_data[15:0]} << half_shift;
                wstrb = 4'b0011 << {addr_low[1], 1'b0};
            end
            default: begin
                wdata = store_data;
                wstrb = 4'b1111;
            end
        endcase
    end

    always_comb begin
        case (funct3)
            mem_byte:   load_data = {{24{byte_sel[7]}}, byte_sel};
            mem_byte_u: load_data = {24'b0, byte_sel};
            mem_half:   load_data = {{16{half_sel[15]}}, half_sel};
            mem_half_u: load_data = {16'b0, half_sel};
            default:    load_data = bus_rdata;
        endcase
    end

endmodule

`default_nettype wire

// File: common/axi_pkg.sv
/* axi_pkg: AXI4 channel payloads and encodings for single-beat
   transfers, plus the data SRAM geometry */
`default_nettype none

package axi_pkg;

    localparam int axi_addr_w = 32;
    localparam int axi_data_w = 32;
    localparam int axi_strb_w = axi_data_w / 8;
    localparam int axi_id_w = 4;

    localparam logic [axi_id_w-1:0] axi_id = 4'd1;   // the only id in use
    localparam logic [7:0] axi_len_single = 8'd0;    // one beat

    localparam int sram_words = 256;
    localparam int sram_idx_w = $clog2(sram_words);

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_e;

    // read and write address channels share one layout
    typedef struct packed {
        logic [axi_addr_w-1:0] addr;
        logic [axi_id_w-1:0]   id;
        logic [7:0]            len;
        logic [2:0]            size;
        axi_burst_e            burst;
    } axi_ax_t;

    typedef axi_ax_t axi_aw_t;
    typedef axi_ax_t axi_ar_t;

    typedef struct packed {
        logic [axi_data_w-1:0] data;
        logic [axi_strb_w-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        axi_resp_e           resp;
        logic [axi_id_w-1:0] id;
    } axi_b_t;

    typedef struct packed {
        logic [axi_data_w-1:0] data;
        axi_resp_e             resp;
        logic [axi_id_w-1:0]   id;
        logic                  last;
    } axi_r_t;

endpackage

`default_nettype wire

// File: common/lsu_pkg.sv
/* lsu_pkg: pipeline-side types for the memory stage,
   covering access kinds and the execute and write-back payloads */
`default_nettype none

package lsu_pkg;

    localparam int xlen = 32;        // data and address width
    localparam int rd_width = 5;
    localparam int csr_wr_width = 4;

    // access kind, encoded as the load/store funct3
    typedef enum logic [2:0] {
        mem_byte   = 3'b000,
        mem_half   = 3'b001,
        mem_word   = 3'b010,
        mem_byte_u = 3'b100,
        mem_half_u = 3'b101
    } mem_op_e;

    typedef struct packed {
        logic [xlen-1:0]         pc;
        logic [xlen-1:0]         result;       // address for loads and stores
        logic [xlen-1:0]         store_data;
        logic [rd_width-1:0]     rd;
        logic                    reg_write;
        logic [csr_wr_width-1:0] csr_write;
        logic [xlen-1:0]         csr_value;
        logic                    jump;
        logic                    mem_read;
        logic                    mem_write;
        mem_op_e                 funct3;
    } exe_to_mem_t;

    typedef struct packed {
        logic [xlen-1:0]         pc;
        logic [xlen-1:0]         result;
        logic [xlen-1:0]         load_data;    // aligned and extended
        logic [rd_width-1:0]     rd;
        logic                    reg_write;
        logic [csr_wr_width-1:0] csr_write;
        logic [xlen-1:0]         csr_value;
        logic                    jump;
        logic                    mem_read;
    } mem_to_wb_t;

endpackage

`default_nettype wire
